// File: verif/rsa_vectors.txt
# op n d a expected (hex); EVEN keeps the previous result as expected
# ops are RUN EVEN BUSYWR BADSEL
RUN BB 7 2 80
RUN BB FF 2 2B
RUN BB 10 3 45
RUN CA1 AC1 AE6 41
EVEN BC 7 2 41
RUN BB 0 5 1
RUN FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 1 0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF 0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF0123456789ABCDEF
BUSYWR CA1 AC1 AE6 41
BADSEL BB 7 2 80
RUN CA1 11 41 AE6

// File: rsa_top.f
+incdir+rtl
rtl/rsa_pkg.sv
rtl/rsa_key_regs.sv
rtl/rsa_mont_mul.sv
rtl/rsa_exp_core.sv
rtl/rsa_top.sv
verif/tb_clk_gen.sv
verif/tb_rsa_monitor.sv
verif/rsa_checker.sv
verif/tb_rsa_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rsa_top
FILELIST  ?= rsa_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module tb_rsa_top;

	import rsa_pkg::*;

	localparam logic [1:0] OP_RUN    = 2'd0;
	localparam logic [1:0] OP_EVEN   = 2'd1;
	localparam logic [1:0] OP_BUSYWR = 2'd2;
	localparam logic [1:0] OP_BADSEL = 2'd3;
	localparam int W = `RSA_WIDTH;
	// start to done worst case, in cycles
	localparam longint BOUND = 2 + (W + 1) + W * (2 * (W + 2) + 2);
	localparam longint CLK_NS = 8;

	logic         clk, rst;
	logic         wr_en, start, test_begin, test_end;
	rsa_wsel_t    wr_sel;
	rsa_widx_t    wr_idx;
	rsa_word_t    wr_data;
	logic         busy, done, key_err, wr_err;
	rsa_operand_t result, expected;
	logic [1:0]   op;
	int           pass_cnt, fail_cnt;
	int           seed;
	logic         loaded;
	longint       timeout_ns;

	logic [1:0]   vec_op[$];
	rsa_operand_t vec_n[$], vec_d[$], vec_a[$], vec_e[$];

	tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst(rst));

	rsa_top rsa_top_i (
		.i_clk(clk), .i_rst(rst), .i_wr_en(wr_en), .i_wr_sel(wr_sel), .i_wr_idx(wr_idx),
		.i_wr_data(wr_data), .i_start(start), .o_busy(busy), .o_done(done),
		.o_result(result), .o_key_err(key_err), .o_wr_err(wr_err)
	);

	tb_rsa_monitor u_monitor (
		.i_clk(clk), .i_rst(rst), .i_busy(busy), .i_done(done), .i_result(result),
		.i_key_err(key_err), .i_wr_err(wr_err), .i_test_begin(test_begin),
		.i_test_end(test_end), .i_op(op), .i_expected(expected),
		.o_pass_cnt(pass_cnt), .o_fail_cnt(fail_cnt)
	);

	task automatic read_vectors(output logic ok);
		int    fd, cnt;
		string line, op_s;
		rsa_operand_t n, d, a, e;
		ok = 1'b0;
		fd = $fopen("verif/rsa_vectors.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				cnt  = $fgets(line, fd);
				if (line.len() > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%s %h %h %h %h", op_s, n, d, a, e);
					if (cnt == 5) begin
						vec_op.push_back(op_s == "RUN" ? OP_RUN : op_s == "EVEN" ? OP_EVEN :
							op_s == "BUSYWR" ? OP_BUSYWR : OP_BADSEL);
						vec_n.push_back(n);
						vec_d.push_back(d);
						vec_a.push_back(a);
						vec_e.push_back(e);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic write_word(input rsa_wsel_t sel, input int idx, input rsa_word_t data);
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_sel  <= sel;
		wr_idx  <= rsa_widx_t'(idx);
		wr_data <= data;
		@(posedge clk);
		wr_en   <= 1'b0;
	endtask

	// all 24 words in a shuffled order with random idle gaps
	task automatic load_operands(input rsa_operand_t n, input rsa_operand_t d,
		input rsa_operand_t a);
		int order[24];
		int j, tmp, idx, gap;
		for (int k = 0; k < 24; k++)
			order[k] = k;
		for (int k = 23; k > 0; k--) begin
			j        = {$random(seed)} % (k + 1);
			tmp      = order[k];
			order[k] = order[j];
			order[j] = tmp;
		end
		for (int k = 0; k < 24; k++) begin
			idx = order[k] % 8;
			gap = {$random(seed)} % 3;
			repeat (gap) @(posedge clk);
			case (order[k] / 8)
				0:       write_word(SEL_N, idx, n[idx*32 +: 32]);
				1:       write_word(SEL_D, idx, d[idx*32 +: 32]);
				default: write_word(SEL_A, idx, a[idx*32 +: 32]);
			endcase
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic wait_done();
		do @(negedge clk); while (!done);
	endtask

	task automatic run_test(input int i);
		@(posedge clk);
		test_begin <= 1'b1;
		op         <= vec_op[i];
		expected   <= vec_e[i];
		@(posedge clk);
		test_begin <= 1'b0;
		case (vec_op[i])
			OP_EVEN: begin
				for (int k = 0; k < 8; k++)
					write_word(SEL_N, k, vec_n[i][k*32 +: 32]);
				pulse_start();
				do @(negedge clk); while (!key_err);
				repeat (4) @(posedge clk);
			end
			OP_BUSYWR: begin
				load_operands(vec_n[i], vec_d[i], vec_a[i]);
				pulse_start();
				do @(negedge clk); while (!busy);
				write_word(SEL_D, 0, 32'hffff_ffff); // must be dropped
				wait_done();
			end
			OP_BADSEL: begin
				load_operands(vec_n[i], vec_d[i], vec_a[i]);
				write_word(SEL_RSVD, 0, 32'h0bad_0bad);
				pulse_start();
				wait_done();
			end
			default: begin
				load_operands(vec_n[i], vec_d[i], vec_a[i]);
				pulse_start();
				wait_done();
			end
		endcase
		repeat (2) @(posedge clk);
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
		@(posedge clk);
	endtask

	initial begin
		logic ok;
		wr_en      = 1'b0;
		wr_sel     = SEL_N;
		wr_idx     = '0;
		wr_data    = '0;
		start      = 1'b0;
		test_begin = 1'b0;
		test_end   = 1'b0;
		op         = OP_RUN;
		expected   = '0;
		seed       = 92;
		loaded     = 1'b0;
		read_vectors(ok);
		if (!ok || vec_op.size() == 0) begin
			$display("could not read any test from verif/rsa_vectors.txt");
			$display("SIMULATION FAILED");
			$finish;
		end else begin
			timeout_ns = longint'(vec_op.size()) * BOUND * CLK_NS + 200000;
			loaded     = 1'b1;
			@(posedge rst);
			for (int i = 0; i < vec_op.size(); i++)
				run_test(i);
			$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0 && pass_cnt == vec_op.size())
				$display("SIMULATION PASSED");
			else
				$display("SIMULATION FAILED");
			$finish;
		end
	end

	// watchdog
	initial begin
		wait (loaded);
		#(timeout_ns);
		$display("run timed out waiting for o_done");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/rsa_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_checker (
	input logic                  i_clk,
	input logic                  i_rst,
	input logic                  i_busy,
	input logic                  i_done,
	input rsa_pkg::rsa_operand_t i_result,
	input logic                  i_key_err,
	input logic                  i_wr_err
);

	// single-cycle pulses
	a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst) i_done |=> !i_done)
		else $error("o_done high for two cycles");
	a_key_err_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_key_err |=> !i_key_err)
		else $error("o_key_err high for two cycles");
	a_wr_err_pulse: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_wr_err |=> !i_wr_err)
		else $error("o_wr_err high for two cycles");

	a_result_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
		i_busy |-> $stable(i_result))
		else $error("o_result moved while busy");

	a_done_idle: assert property (@(posedge i_clk) disable iff (!i_rst) i_done |-> !i_busy)
		else $error("o_busy still high with o_done");

endmodule

bind rsa_top rsa_checker u_rsa_checker (
	.i_clk     (i_clk),
	.i_rst     (i_rst),
	.i_busy    (o_busy),
	.i_done    (o_done),
	.i_result  (o_result),
	.i_key_err (o_key_err),
	.i_wr_err  (o_wr_err)
);

`default_nettype wire

// File: verif/tb_rsa_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_monitor (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_busy,
	input  logic                  i_done,
	input  rsa_pkg::rsa_operand_t i_result,
	input  logic                  i_key_err,
	input  logic                  i_wr_err,
	input  logic                  i_test_begin,
	input  logic                  i_test_end,
	input  logic [1:0]            i_op,
	input  rsa_pkg::rsa_operand_t i_expected,
	output int                    o_pass_cnt,
	output int                    o_fail_cnt
);

	import rsa_pkg::*;

	localparam logic [1:0] OP_RUN    = 2'd0;
	localparam logic [1:0] OP_EVEN   = 2'd1;
	localparam logic [1:0] OP_BUSYWR = 2'd2;
	localparam logic [1:0] OP_BADSEL = 2'd3;

	rsa_operand_t cur_exp;
	rsa_operand_t prev_result;
	logic [1:0]   cur_op;
	logic         seen_done, seen_kerr, seen_werr, seen_busy;
	int           test_errs;
	int           test_num;

	always @(posedge i_clk) begin
		if (!i_rst) begin
			o_pass_cnt  = 0;
			o_fail_cnt  = 0;
			test_num    = 0;
			test_errs   = 0;
			prev_result = '0;
		end else begin
			// result may only move together with done
			if (i_result !== prev_result && !i_done) begin
				$display("error at %0d ns: o_result changed without o_done, was %h now %h",
					$time, prev_result, i_result);
				test_errs = test_errs + 1;
			end
			prev_result = i_result;
			if (i_test_begin) begin
				cur_op    = i_op;
				cur_exp   = i_expected;
				seen_done = 1'b0;
				seen_kerr = 1'b0;
				seen_werr = 1'b0;
				seen_busy = 1'b0;
				test_errs = 0;
				test_num  = test_num + 1;
			end else begin
				if (i_busy)    seen_busy = 1'b1;
				if (i_key_err) seen_kerr = 1'b1;
				if (i_wr_err)  seen_werr = 1'b1;
				if (i_done) begin
					seen_done = 1'b1;
					if (i_result !== cur_exp) begin
						$display("error at %0d ns: o_result expected %h got %h",
							$time, cur_exp, i_result);
						test_errs = test_errs + 1;
					end
				end
			end
			if (i_test_end) begin
				case (cur_op)
					OP_EVEN: begin
						if (!seen_kerr) begin
							$display("test %0d: even modulus gave no o_key_err pulse", test_num);
							test_errs = test_errs + 1;
						end
						if (seen_busy || seen_done) begin
							$display("test %0d: even modulus still started the core", test_num);
							test_errs = test_errs + 1;
						end
						if (i_result !== cur_exp) begin
							$display("error at %0d ns: o_result expected %h got %h",
								$time, cur_exp, i_result);
							test_errs = test_errs + 1;
						end
					end
					default: begin
						if (!seen_done) begin
							$display("test %0d: no o_done pulse seen", test_num);
							test_errs = test_errs + 1;
						end
						if (seen_kerr) begin
							$display("test %0d: unexpected o_key_err pulse", test_num);
							test_errs = test_errs + 1;
						end
						// only the error cases expect a write error
						if (seen_werr != (cur_op == OP_BUSYWR || cur_op == OP_BADSEL)) begin
							$display("test %0d: o_wr_err pulse seen %0b, expected %0b",
								test_num, seen_werr, cur_op != OP_RUN);
							test_errs = test_errs + 1;
						end
					end
				endcase
				if (test_errs == 0) begin
					o_pass_cnt = o_pass_cnt + 1;
					$display("test %0d op %0d passed", test_num, cur_op);
				end else begin
					o_fail_cnt = o_fail_cnt + 1;
					$display("test %0d op %0d failed with %0d errors", test_num, cur_op, test_errs);
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int HALF_NS    = 4,
	parameter int RST_CYCLES = 16
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_NS) o_clk = ~o_clk;
	end

	// active low reset, released on a rising edge
	initial begin
		o_rst = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/rsa_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsa_top (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_wr_en,
	input  rsa_pkg::rsa_wsel_t    i_wr_sel,
	input  rsa_pkg::rsa_widx_t    i_wr_idx,
	input  rsa_pkg::rsa_word_t    i_wr_data,
	input  logic                  i_start,
	output logic                  o_busy,
	output logic                  o_done,
	output rsa_pkg::rsa_operand_t o_result,
	output logic                  o_key_err,
	output logic                  o_wr_err
);

	import rsa_pkg::*;

	rsa_operand_t key_n;
	rsa_operand_t key_d;
	rsa_operand_t key_a;
	logic         go;
	logic         busy;

	assign o_busy = busy;

	rsa_key_regs u_key_regs (
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_wr_en   (i_wr_en),
		.i_wr_sel  (i_wr_sel),
		.i_wr_idx  (i_wr_idx),
		.i_wr_data (i_wr_data),
		.i_start   (i_start),
		.i_busy    (busy),      // gates writes and starts
		.o_n       (key_n),
		.o_d       (key_d),
		.o_a       (key_a),
		.o_go      (go),
		.o_key_err (o_key_err),
		.o_wr_err  (o_wr_err)
	);

	rsa_exp_core u_exp_core (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_go     (go),
		.i_n      (key_n),
		.i_d      (key_d),
		.i_a      (key_a),
		.o_busy   (busy),
		.o_done   (o_done),
		.o_result (o_result)
	);

endmodule

`default_nettype wire

// File: rtl/rsa_exp_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_exp_core (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_go,
	input  rsa_pkg::rsa_operand_t i_n,
	input  rsa_pkg::rsa_operand_t i_d,
	input  rsa_pkg::rsa_operand_t i_a,
	output logic                  o_busy,
	output logic                  o_done,
	output rsa_pkg::rsa_operand_t o_result
);

	import rsa_pkg::*;

	localparam int W  = `RSA_WIDTH;
	localparam int IW = $clog2(W) + 1;
	localparam logic [IW-1:0] LAST = IW'(W);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PRE,  // message into montgomery form
		S_SEL,  // pick multiply or square for exponent bit
		S_MUL,
		S_SQR
	} state_t;

	state_t        state_r, state_w;
	logic [IW-1:0] iter_r, iter_w;
	rsa_operand_t  t_r, t_w;       // base, montgomery form
	rsa_operand_t  m_r, m_w;       // running result
	rsa_operand_t  result_r, result_w;
	logic          done_r, done_w;
	logic          mm_start_r, mm_start_w;
	rsa_operand_t  mm_a_r, mm_a_w;
	rsa_operand_t  mm_b_r, mm_b_w;
	rsa_operand_t  mm_result;
	logic          mm_done;
	logic [W:0]    dbl;            // 2t before reduction
	logic [W:0]    dbl_mod;

	rsa_mont_mul u_mont_mul (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_start  (mm_start_r),
		.i_mdl    (i_n),
		.i_a      (mm_a_r),
		.i_b      (mm_b_r),
		.o_result (mm_result),
		.o_done   (mm_done)
	);

	// modular doubling for the pre-shift
	assign dbl     = {t_r, 1'b0};
	assign dbl_mod = (dbl >= {1'b0, i_n}) ? dbl - {1'b0, i_n} : dbl;

	assign o_busy   = (state_r != S_IDLE);
	assign o_done   = done_r;
	assign o_result = result_r;

	always_comb begin
		state_w    = state_r;
		iter_w     = iter_r;
		t_w        = t_r;
		m_w        = m_r;
		result_w   = result_r;
		done_w     = 1'b0;
		mm_start_w = 1'b0;
		mm_a_w     = mm_a_r;
		mm_b_w     = mm_b_r;
		case (state_r)
			S_IDLE: begin
				if (i_go) begin
					state_w = S_PRE;
					iter_w  = '0;
					t_w     = i_a;
					m_w     = rsa_operand_t'(1);
				end
			end
			S_PRE: begin
				if (iter_r == LAST) begin
					state_w = S_SEL;
					iter_w  = '0;
				end else begin
					t_w    = dbl_mod[W-1:0];
					iter_w = iter_r + 1'b1;
				end
			end
			S_SEL: begin
				if (iter_r == LAST) begin
					state_w  = S_IDLE;
					result_w = m_r;
					done_w   = 1'b1;
				end else if (i_d[iter_r[IW-2:0]]) begin
					state_w    = S_MUL;   // m * t first
					mm_a_w     = m_r;
					mm_b_w     = t_r;
					mm_start_w = 1'b1;
				end else begin
					state_w    = S_SQR;
					mm_a_w     = t_r;
					mm_b_w     = t_r;
					mm_start_w = 1'b1;
				end
			end
			S_MUL: begin
				if (mm_done) begin
					m_w        = mm_result;
					state_w    = S_SQR;
					mm_a_w     = t_r;
					mm_b_w     = t_r;
					mm_start_w = 1'b1;
				end
			end
			S_SQR: begin
				if (mm_done) begin
					t_w     = mm_result;
					iter_w  = iter_r + 1'b1;
					state_w = S_SEL;
				end
			end
			default: state_w = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r    <= S_IDLE;
			iter_r     <= '0;
			result_r   <= '0;
			done_r     <= 1'b0;
			mm_start_r <= 1'b0;
		end else begin
			state_r    <= state_w;
			iter_r     <= iter_w;
			result_r   <= result_w;
			done_r     <= done_w;
			mm_start_r <= mm_start_w;
		end
	end

	// working operands
	always_ff @(posedge i_clk) begin
		t_r    <= t_w;
		m_r    <= m_w;
		mm_a_r <= mm_a_w;
		mm_b_r <= mm_b_w;
	end

endmodule

`default_nettype wire

// File: rtl/rsa_mont_mul.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_mont_mul (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  rsa_pkg::rsa_operand_t i_mdl, // odd modulus
	input  rsa_pkg::rsa_operand_t i_a,   // scanned bit by bit
	input  rsa_pkg::rsa_operand_t i_b,
	output rsa_pkg::rsa_operand_t o_result,
	output logic                  o_done
);

	import rsa_pkg::*;

	localparam int W  = `RSA_WIDTH;
	localparam int IW = $clog2(W) + 1;
	localparam logic [IW-1:0] LAST = IW'(W);
	localparam logic S_IDLE = 1'b0;
	localparam logic S_CALC = 1'b1;

	logic          state_r, state_w;
	logic [IW-1:0] iter_r, iter_w;
	logic [W:0]    acc_r, acc_w;  // kept below 2n
	logic          done_r, done_w;
	rsa_operand_t  addend;
	logic [W+1:0]  sum1;
	logic [W+1:0]  sum2;

	// one add-and-halve step
	assign addend = i_a[iter_r[IW-2:0]] ? i_b : '0;
	assign sum1   = {1'b0, acc_r} + {2'b00, addend};
	assign sum2   = sum1 + (sum1[0] ? {2'b00, i_mdl} : '0); // make it even

	assign o_result = acc_r[W-1:0];
	assign o_done   = done_r;

	always_comb begin
		state_w = state_r;
		iter_w  = iter_r;
		acc_w   = acc_r;
		done_w  = 1'b0;
		case (state_r)
			S_IDLE: begin
				if (i_start) begin
					state_w = S_CALC;
					iter_w  = '0;
					acc_w   = '0;
				end
			end
			S_CALC: begin
				if (iter_r != LAST) begin
					acc_w  = sum2[W+1:1];
					iter_w = iter_r + 1'b1;
				end else begin
					// final conditional subtraction
					if (acc_r >= {1'b0, i_mdl})
						acc_w = acc_r - {1'b0, i_mdl};
					done_w  = 1'b1;
					state_w = S_IDLE;
				end
			end
			default: state_w = S_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r <= S_IDLE;
			iter_r  <= '0;
			acc_r   <= '0;
			done_r  <= 1'b0;
		end else begin
			state_r <= state_w;
			iter_r  <= iter_w;
			acc_r   <= acc_w;
			done_r  <= done_w;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rsa_key_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rsa_cfg.svh"

module rsa_key_regs (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_wr_en,
	input  rsa_pkg::rsa_wsel_t    i_wr_sel,
	input  rsa_pkg::rsa_widx_t    i_wr_idx,
	input  rsa_pkg::rsa_word_t    i_wr_data,
	input  logic                  i_start,
	input  logic                  i_busy,
	output rsa_pkg::rsa_operand_t o_n,
	output rsa_pkg::rsa_operand_t o_d,
	output rsa_pkg::rsa_operand_t o_a,
	output logic                  o_go,
	output logic                  o_key_err,
	output logic                  o_wr_err
);

	import rsa_pkg::*;

	localparam int SHIFT = $clog2(`RSA_WORD);
	localparam int BW    = $clog2(`RSA_WIDTH);

	rsa_operand_t  n_r;
	rsa_operand_t  d_r;
	rsa_operand_t  a_r;
	logic [BW-1:0] wr_base;   // bit offset of the addressed word
	logic          locked;
	logic          wr_ok;
	logic          start_ok;
	logic          go_r;
	logic          key_err_r;
	logic          wr_err_r;

	// go_r counts as busy too, the core only raises busy one cycle later
	assign locked   = i_busy | go_r;
	assign wr_ok    = i_wr_en & ~locked;
	assign start_ok = i_start & ~locked;
	assign wr_base  = {i_wr_idx, {SHIFT{1'b0}}};

	assign o_n       = n_r;
	assign o_d       = d_r;
	assign o_a       = a_r;
	assign o_go      = go_r;
	assign o_key_err = key_err_r;
	assign o_wr_err  = wr_err_r;

	// operand storage
	always_ff @(posedge i_clk) begin
		if (wr_ok) begin
			case (i_wr_sel)
				SEL_N:   n_r[wr_base +: `RSA_WORD] <= i_wr_data;
				SEL_D:   d_r[wr_base +: `RSA_WORD] <= i_wr_data;
				SEL_A:   a_r[wr_base +: `RSA_WORD] <= i_wr_data;
				default: ; // reserved select, nothing stored
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			go_r      <= 1'b0;
			key_err_r <= 1'b0;
			wr_err_r  <= 1'b0;
		end else begin
			// montgomery needs an odd modulus
			go_r      <= start_ok & n_r[0];
			key_err_r <= start_ok & ~n_r[0];
			wr_err_r  <= i_wr_en & (locked | (i_wr_sel == SEL_RSVD));
		end
	end

endmodule

`default_nettype wire

// File: rtl/rsa_pkg.sv
`default_nettype none

package rsa_pkg;

	`include "rsa_cfg.svh"

	// full-width operand (modulus, exponent, message, result)
	typedef logic [`RSA_WIDTH-1:0] rsa_operand_t;

	// one word on the write bus
	typedef logic [`RSA_WORD-1:0] rsa_word_t;

	// write target select
	typedef enum logic [1:0] {
		SEL_N    = 2'd0, // modulus
		SEL_D    = 2'd1, // private exponent
		SEL_A    = 2'd2, // cipher text
		SEL_RSVD = 2'd3  // unused, write is discarded
	} rsa_wsel_t;

	// word index, 0 is the least significant word
	typedef logic [$clog2(`RSA_NWORDS)-1:0] rsa_widx_t;

endpackage

`default_nettype wire

// File: rtl/rsa_cfg.svh
`ifndef RSA_CFG_SVH
`define RSA_CFG_SVH

// operand width in bits
`define RSA_WIDTH 256

// write bus width
`define RSA_WORD 32

// words per operand
`define RSA_NWORDS (`RSA_WIDTH / `RSA_WORD)

`endif
